//--- bench/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model of the ALU operations
////////////////////////////////////////////////////////////

// Defined codes are 0 to 3 and 5 to 10
function automatic logic is_reserved_op(input logic [3:0] op);
	return (op == 4'd4) || (op > 4'd10);
endfunction

function automatic logic [31:0] model_result(
	input logic [3:0]  op,
	input logic [31:0] a,
	input logic [31:0] b
);
	logic [63:0]        wide_a;
	logic signed [63:0] sext_a;
	logic [5:0]         amt;
	logic [31:0]        r;
	wide_a = {32'b0, a};
	sext_a = {{32{a[31]}}, a};
	amt    = b[5:0];
	case (op)
		op_and: r = a & b;
		op_or:  r = a | b;
		op_xor: r = a ^ b;
		op_nor: r = ~(a | b);
		op_add: r = a + b;
		op_sub: r = a - b;
		// Signed order by flipping the sign bits
		op_slt: r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
		// 64-bit shifts push large amounts out on their own
		op_srl: r = 32'(wide_a >> amt);
		op_sll: r = 32'(wide_a << amt);
		op_sra: r = 32'(sext_a >>> amt);
		default: r = '0;
	endcase
	return r;
endfunction

function automatic alu_flags_t model_flags(
	input logic [3:0]  op,
	input logic [31:0] a,
	input logic [31:0] b
);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic signed [63:0] wide;
	logic [31:0]        r;
	alu_flags_t         f;
	sa   = {{32{a[31]}}, a};
	sb   = {{32{b[31]}}, b};
	wide = (op == op_sub) ? (sa - sb) : (sa + sb);
	r    = model_result(op, a, b);
	f.reserved = is_reserved_op(op);
	f.equal    = !f.reserved && (a == b);
	f.zero     = !f.reserved && (r == '0);
	// Overflow when the exact sum no longer fits in 32 signed bits
	f.overflow = (op == op_add || op == op_sub) && (wide[63:31] != {33{wide[31]}});
	return f;
endfunction

`endif

//--- bench/alu_unit_tb.sv
`timescale 1ns/1ns

module alu_unit_tb
	import alu_pkg::*;
();

	localparam int NUM_REGS = 16;
	localparam int SEED     = 44;
	// About 100 load cycles and 600 instructions with gaps fit well below this
	localparam int MAX_CYCLES = 2000;

	typedef struct {
		int                    due;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     result;
		alu_flags_t            flags;
	} exp_item_t;

	logic                  clk;
	logic                  rst_n;
	logic                  instr_valid;
	alu_instr_t            instr;
	logic                  load_valid;
	logic [REG_ADDR_W-1:0] load_addr;
	logic [DATA_W-1:0]     load_data;
	logic                  res_valid;
	logic [REG_ADDR_W-1:0] res_rd;
	logic [DATA_W-1:0]     res_data;
	alu_flags_t            res_flags;

	logic [DATA_W-1:0] model_regs [0:NUM_REGS-1];
	exp_item_t         exp_q [$];
	int                cycles = 0;
	int                checked = 0;

	tb_clock u_clock (
		.clk  (clk),
		.rst_n(rst_n)
	);

	alu_unit_top #(
		.NUM_REGS(NUM_REGS)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_valid(instr_valid),
		.instr      (instr),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.res_valid  (res_valid),
		.res_rd     (res_rd),
		.res_data   (res_data),
		.res_flags  (res_flags)
	);

	`include "alu_model.svh"

	////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(
		input logic [31:0] actual,
		input logic [31:0] expected,
		input string       what
	);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rand_value();
		logic [31:0] v;
		case ($urandom % 8)
			0: v = '0;
			1: v = '1;
			2: v = 32'h8000_0000;
			3: v = 32'd31;
			4: v = 32'd32;
			5: v = 32'd63;
			6: v = 32'h7fff_ffff;
			default: v = $urandom;
		endcase
		return v;
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			load_valid  <= 1'b0;
		end
	endtask

	// Model state moves at issue in program order
	task automatic issue(input logic [3:0] op, input int rd, input int rs, input int rt);
		exp_item_t item;
		@(posedge clk);
		item.due    = cycles + 3;
		item.rd     = 5'(rd);
		item.result = model_result(op, model_regs[rs], model_regs[rt]);
		item.flags  = model_flags(op, model_regs[rs], model_regs[rt]);
		exp_q.push_back(item);
		if (rd != 0) begin
			model_regs[rd] = item.result;
		end
		instr_valid <= 1'b1;
		load_valid  <= 1'b0;
		instr       <= {op, 5'(rd), 5'(rs), 5'(rt)};
	endtask

	task automatic load_reg(input int addr, input logic [31:0] data);
		@(posedge clk);
		instr_valid <= 1'b0;
		load_valid  <= 1'b1;
		load_addr   <= 5'(addr);
		load_data   <= data;
		if (addr != 0) begin
			model_regs[addr] = data;
		end
	endtask

	// Register 0 is loaded too and must stay zero
	task automatic load_all();
		for (int r = 0; r < NUM_REGS; r++) begin
			load_reg(r, rand_value());
		end
		idle(1);
	endtask

	// Wait for every result and its writeback
	task automatic drain();
		idle(1);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
	endtask

	task automatic random_instr();
		int         pick;
		logic [3:0] op;
		if ($urandom % 5 == 0) begin
			pick = int'($urandom % 6);
			op   = (pick == 0) ? 4'd4 : 4'(10 + pick);
		end else begin
			pick = int'($urandom % 10);
			op   = (pick < 4) ? 4'(pick) : 4'(pick + 1);
		end
		issue(op, int'($urandom % NUM_REGS), int'($urandom % NUM_REGS),
			int'($urandom % NUM_REGS));
		if ($urandom % 4 == 0) begin
			idle(1);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Cycle count and result checking
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			fail_run("Timeout, the run did not finish within the cycle limit");
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		exp_item_t item;
		if (rst_n && res_valid) begin
			if (exp_q.size() == 0) begin
				fail_run("Result pulse appeared with no instruction in flight");
			end else begin
				item = exp_q.pop_front();
				if (item.due != cycles) begin
					fail_run("Result pulse arrived in the wrong cycle");
				end else begin
					check_value(32'(res_rd), 32'(item.rd), "res_rd");
					check_value(res_data, item.result, "res_data");
					check_value({28'b0, res_flags}, {28'b0, item.flags}, "res_flags");
					checked++;
				end
			end
		end else if (rst_n && exp_q.size() != 0 && exp_q[0].due <= cycles) begin
			fail_run("Expected result pulse is missing");
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		instr_valid = 1'b0;
		instr       = '0;
		load_valid  = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		void'($urandom(SEED));
		wait (rst_n === 1'b1);
		idle(3);

		// Registers are zero after reset
		issue(op_add, 3, 1, 2);
		drain();

		// Dependent chain through both bypass paths and register 0
		load_all();
		issue(op_add, 4, 1, 2);
		issue(op_xor, 5, 4, 1);
		idle(1);
		issue(op_sub, 6, 5, 4);
		issue(op_sll, 0, 6, 5);
		issue(op_or, 7, 0, 6);
		drain();

		for (int round = 0; round < 6; round++) begin
			load_all();
			repeat (100) begin
				random_instr();
			end
			drain();
		end

		$display("%0d results checked", checked);
		$display("TEST OK");
		$finish;
	end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- design/alu_decode.sv
`timescale 1ns/1ns

module alu_decode
	import alu_pkg::*;
#(
	parameter int NUM_REGS = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  alu_instr_t            instr,
	input  wb_port_t              ex_fwd,
	input  wb_port_t              wb,
	input  logic [DATA_W-1:0]     rd_data_a,
	input  logic [DATA_W-1:0]     rd_data_b,
	output logic [REG_ADDR_W-1:0] rd_addr_a,
	output logic [REG_ADDR_W-1:0] rd_addr_b,
	output dec_stage_t            dec_q
);

	////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////

	// Youngest in-flight result first, then writeback, then the file
	function automatic logic [DATA_W-1:0] pick_operand(
		input logic [REG_ADDR_W-1:0] addr,
		input logic [DATA_W-1:0]     rf_data,
		input wb_port_t              fwd,
		input wb_port_t              wbp
	);
		logic [DATA_W-1:0] val;
		if (addr == '0 || int'(addr) >= NUM_REGS) begin
			val = '0;
		end else if (fwd.en && fwd.addr == addr) begin
			val = fwd.data;
		end else if (wbp.en && wbp.addr == addr) begin
			val = wbp.data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	logic [DATA_W-1:0] opnd_a;
	logic [DATA_W-1:0] opnd_b;

	assign rd_addr_a = instr.rs;
	assign rd_addr_b = instr.rt;

	assign opnd_a = pick_operand(instr.rs, rd_data_a, ex_fwd, wb);
	assign opnd_b = pick_operand(instr.rt, rd_data_b, ex_fwd, wb);

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	logic                  valid_q;
	logic [3:0]            op_q;
	logic [REG_ADDR_W-1:0] rd_q;
	logic [DATA_W-1:0]     a_q;
	logic [DATA_W-1:0]     b_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= instr_valid;
		end
	end

	// Payload only moves on an issued instruction
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			op_q <= instr.op;
			rd_q <= instr.rd;
			a_q  <= opnd_a;
			b_q  <= opnd_b;
		end
	end

	always_comb begin
		dec_q.valid = valid_q;
		dec_q.op    = op_q;
		dec_q.rd    = rd_q;
		dec_q.a     = a_q;
		dec_q.b     = b_q;
	end

endmodule

//--- design/alu_execute.sv
`timescale 1ns/1ns

module alu_execute
	import alu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  dec_stage_t dec_q,
	output wb_port_t   ex_fwd,
	output exe_stage_t exe_q
);

	////////////////////////////////////////////////////////////
	// Operators
	////////////////////////////////////////////////////////////

	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] add_out;
	logic [DATA_W-1:0] sub_out;
	logic [DATA_W-1:0] slt_out;
	logic [DATA_W-1:0] srl_out;
	logic [DATA_W-1:0] sll_out;
	logic [DATA_W-1:0] sra_small;
	logic [DATA_W-1:0] sra_out;
	logic              add_ovf;
	logic              sub_ovf;
	logic [5:0]        shamt;
	logic              shift_big;

	assign a = dec_q.a;
	assign b = dec_q.b;

	assign add_out = a + b;
	assign sub_out = a - b;

	// Signed overflow from the sign bits
	assign add_ovf = (a[DATA_W-1] == b[DATA_W-1]) && (add_out[DATA_W-1] != a[DATA_W-1]);
	assign sub_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (sub_out[DATA_W-1] != a[DATA_W-1]);

	assign slt_out = {{(DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};

	// Amount of 32 or more shifts everything out
	assign shamt     = b[5:0];
	assign shift_big = shamt[5];

	// Arithmetic shift kept in its own signed expression
	assign sra_small = $signed(a) >>> shamt[4:0];

	assign srl_out = shift_big ? '0 : (a >> shamt[4:0]);
	assign sll_out = shift_big ? '0 : (a << shamt[4:0]);
	assign sra_out = shift_big ? {DATA_W{a[DATA_W-1]}} : sra_small;

	////////////////////////////////////////////////////////////
	// Select and flags
	////////////////////////////////////////////////////////////

	logic [DATA_W-1:0] result;
	alu_flags_t        flags;
	logic              reserved;

	always_comb begin
		reserved = 1'b0;
		case (dec_q.op)
			op_and: result = a & b;
			op_or:  result = a | b;
			op_xor: result = a ^ b;
			op_nor: result = ~(a | b);
			op_add: result = add_out;
			op_sub: result = sub_out;
			op_slt: result = slt_out;
			op_srl: result = srl_out;
			op_sll: result = sll_out;
			op_sra: result = sra_out;
			default: begin
				result   = '0;
				reserved = 1'b1;
			end
		endcase
	end

	always_comb begin
		flags.reserved = reserved;
		flags.equal    = (a == b) && !reserved;
		flags.zero     = (result == '0) && !reserved;
		case (dec_q.op)
			op_add:  flags.overflow = add_ovf;
			op_sub:  flags.overflow = sub_ovf;
			default: flags.overflow = 1'b0;
		endcase
	end

	// Result of the instruction held here feeds the decode bypass
	always_comb begin
		ex_fwd.en   = dec_q.valid;
		ex_fwd.addr = dec_q.rd;
		ex_fwd.data = result;
	end

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	logic                  valid_q;
	logic [REG_ADDR_W-1:0] rd_q;
	logic [DATA_W-1:0]     result_q;
	alu_flags_t            flags_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= dec_q.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_q.valid) begin
			rd_q     <= dec_q.rd;
			result_q <= result;
			flags_q  <= flags;
		end
	end

	always_comb begin
		exe_q.valid  = valid_q;
		exe_q.rd     = rd_q;
		exe_q.result = result_q;
		exe_q.flags  = flags_q;
	end

endmodule

//--- design/alu_pkg.sv
package alu_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Shifts and overflow are defined for a 32-bit word
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;

	////////////////////////////////////////////////////////////
	// Operation codes
	////////////////////////////////////////////////////////////

	// Codes 4 and 11 to 15 are reserved
	typedef enum logic [3:0] {
		op_and = 4'd0,
		op_or  = 4'd1,
		op_xor = 4'd2,
		op_nor = 4'd3,
		op_add = 4'd5,
		op_sub = 4'd6,
		op_slt = 4'd7,
		op_srl = 4'd8,
		op_sll = 4'd9,
		op_sra = 4'd10
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////

	// Raw 4-bit op so that reserved codes pass through unchanged
	typedef struct packed {
		logic [3:0]            op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
	} alu_instr_t;

	typedef struct packed {
		logic overflow;
		logic equal;
		logic zero;
		logic reserved;
	} alu_flags_t;

	typedef struct packed {
		logic                  valid;
		logic [3:0]            op;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     a;
		logic [DATA_W-1:0]     b;
	} dec_stage_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     result;
		alu_flags_t            flags;
	} exe_stage_t;

	// Register write request that also serves as a bypass source
	typedef struct packed {
		logic                  en;
		logic [REG_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     data;
	} wb_port_t;

endpackage

//--- design/alu_result.sv
`timescale 1ns/1ns

module alu_result
	import alu_pkg::*;
(
	input  exe_stage_t            exe_q,
	output logic                  res_valid,
	output logic [REG_ADDR_W-1:0] res_rd,
	output logic [DATA_W-1:0]     res_data,
	output alu_flags_t            res_flags,
	output wb_port_t              wb
);

	////////////////////////////////////////////////////////////
	// Result ports
	////////////////////////////////////////////////////////////

	// One-cycle pulse per finished instruction
	assign res_valid = exe_q.valid;
	assign res_rd    = exe_q.rd;
	assign res_data  = exe_q.result;
	assign res_flags = exe_q.flags;

	////////////////////////////////////////////////////////////
	// Writeback request
	////////////////////////////////////////////////////////////

	logic rd_is_zero;

	assign rd_is_zero = (exe_q.rd == '0);

	// Reserved ops still write their zero result
	// Register 0 never gets a request, so it never bypasses either
	always_comb begin
		wb.en   = exe_q.valid && !rd_is_zero;
		wb.addr = exe_q.rd;
		wb.data = exe_q.result;
	end

endmodule

//--- design/alu_unit_top.sv
`timescale 1ns/1ns

module alu_unit_top
	import alu_pkg::*;
#(
	parameter int NUM_REGS = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  alu_instr_t            instr,
	input  logic                  load_valid,
	input  logic [REG_ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0]     load_data,
	output logic                  res_valid,
	output logic [REG_ADDR_W-1:0] res_rd,
	output logic [DATA_W-1:0]     res_data,
	output alu_flags_t            res_flags
);

	logic [REG_ADDR_W-1:0] rd_addr_a;
	logic [REG_ADDR_W-1:0] rd_addr_b;
	logic [DATA_W-1:0]     rd_data_a;
	logic [DATA_W-1:0]     rd_data_b;
	dec_stage_t            dec_q;
	exe_stage_t            exe_q;
	wb_port_t              ex_fwd;
	wb_port_t              wb;

	reg_file #(
		.NUM_REGS(NUM_REGS)
	) u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_valid(load_valid),
		.load_addr (load_addr),
		.load_data (load_data),
		.wb        (wb),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	// Issue edge to dec_q
	alu_decode #(
		.NUM_REGS(NUM_REGS)
	) u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_valid(instr_valid),
		.instr      (instr),
		.ex_fwd     (ex_fwd),
		.wb         (wb),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.dec_q      (dec_q)
	);

	alu_execute u_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.dec_q (dec_q),
		.ex_fwd(ex_fwd),
		.exe_q (exe_q)
	);

	alu_result u_result (
		.exe_q    (exe_q),
		.res_valid(res_valid),
		.res_rd   (res_rd),
		.res_data (res_data),
		.res_flags(res_flags),
		.wb       (wb)
	);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file
	import alu_pkg::*;
#(
	parameter int NUM_REGS = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  load_valid,
	input  logic [REG_ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0]     load_data,
	input  wb_port_t              wb,
	input  logic [REG_ADDR_W-1:0] rd_addr_a,
	input  logic [REG_ADDR_W-1:0] rd_addr_b,
	output logic [DATA_W-1:0]     rd_data_a,
	output logic [DATA_W-1:0]     rd_data_b
);

	// Register 0 has no storage and is hardwired to zero
	logic [DATA_W-1:0] regs [1:NUM_REGS-1];

	// Writeback wins over the load port on the same register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 1; i < NUM_REGS; i++) begin
				if (wb.en && wb.addr == REG_ADDR_W'(i)) begin
					regs[i] <= wb.data;
				end else if (load_valid && load_addr == REG_ADDR_W'(i)) begin
					regs[i] <= load_data;
				end
			end
		end
	end

	// Read ports give zero for unmatched addresses
	always_comb begin
		rd_data_a = '0;
		rd_data_b = '0;
		for (int i = 1; i < NUM_REGS; i++) begin
			if (rd_addr_a == REG_ADDR_W'(i)) begin
				rd_data_a = regs[i];
			end
			if (rd_addr_b == REG_ADDR_W'(i)) begin
				rd_data_b = regs[i];
			end
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module alu_unit_tb -o alu_unit_sim

# The log decides the outcome
./obj_dir/alu_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- src.f
+incdir+bench
design/alu_pkg.sv
design/reg_file.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_result.sv
design/alu_unit_top.sv
bench/tb_clock.sv
bench/alu_unit_tb.sv
